//--- Makefile
# Verilator build and run of the back end testbench

TOP             ?= back_end_core_tb
SIM_DIR         ?= obj_dir
LOG             ?= sim.log
FILELIST        ?= verilog.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message
run: compile
	$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(SIM_DIR) $(LOG)

//--- verif/back_end_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module back_end_core_tb;

    localparam int CLK_PERIOD = 4;
    localparam int ROB_DEPTH  = core_cfg_pkg::ROB_DEPTH_DEF;
    localparam int SB_DEPTH   = core_cfg_pkg::SB_DEPTH_DEF;
    localparam int XLEN       = core_cfg_pkg::XLEN;
    localparam int RW         = core_cfg_pkg::REG_ADDR_W;
    localparam int N_RANDOM   = 200;

    // Cycle budgets of the wait loops in each test
    localparam int INORDER_CYC = 100;
    localparam int FULL_CYC    = 200;
    localparam int STORE_CYC   = 200;
    localparam int BP_CYC      = 200;
    localparam int RANDOM_CYC  = 4000;
    // Sum of the budgets plus room for the fixed-length phases
    localparam int WATCHDOG_NS = CLK_PERIOD *
        (INORDER_CYC + 2 * FULL_CYC + 2 * STORE_CYC + 2 * BP_CYC + RANDOM_CYC + 500);

    logic                     clk;
    logic                     rst_n;
    logic                     alloc;
    core_types_pkg::rob_tag_t alloc_tag;
    logic                     rob_full;
    logic                     fin_valid;
    core_types_pkg::rob_tag_t fin_tag;
    logic                     fin_is_store;
    logic [RW-1:0]            fin_rd;
    logic [XLEN-1:0]          fin_addr;
    logic [XLEN-1:0]          fin_data;
    logic                     upd_en_a;
    logic [RW-1:0]            upd_rd_a;
    logic [XLEN-1:0]          upd_data_a;
    logic                     upd_en_b;
    logic [RW-1:0]            upd_rd_b;
    logic [XLEN-1:0]          upd_data_b;
    logic                     mem_store_valid;
    logic [XLEN-1:0]          mem_store_addr;
    logic [XLEN-1:0]          mem_store_data;
    logic                     store_finish;
    logic [XLEN-1:0]          store_fin_addr;

    //////////////////////////////
    // Reference model state
    //////////////////////////////

    // Instruction contents by tag, fixed at allocation
    logic                     m_store [ROB_DEPTH];
    logic [RW-1:0]            m_rd    [ROB_DEPTH];
    logic [XLEN-1:0]          m_addr  [ROB_DEPTH];
    logic [XLEN-1:0]          m_data  [ROB_DEPTH];
    // Register updates still due, in program order
    logic [RW-1:0]            exp_rd_q   [$];
    logic [XLEN-1:0]          exp_data_q [$];
    // Finished stores not yet released by memory
    logic [XLEN-1:0]          st_addr_q  [$];
    logic [XLEN-1:0]          st_data_q  [$];
    // Allocated tags still waiting for a result
    core_types_pkg::rob_tag_t pend_q     [$];
    core_types_pkg::rob_tag_t exp_tail;
    // Upper address half of each store, keeps store addresses unique
    logic [15:0]              store_seq;
    logic [31:0]              lfsr;

    back_end_core #(
        .ROB_DEPTH (ROB_DEPTH),
        .SB_DEPTH  (SB_DEPTH)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        abort_run();
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    // Galois LFSR, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic int find_store(input logic [XLEN-1:0] addr);
        int idx;
        idx = -1;
        foreach (st_addr_q[i]) begin
            if (st_addr_q[i] == addr) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Oldest due update must match what the port shows
    task automatic pop_update(input string port, input logic [RW-1:0] rd,
                              input logic [XLEN-1:0] data);
        assert (exp_rd_q.size() > 0) else begin
            $display("Register update on port %s at %0t ns with none due", port, $time);
            abort_run();
        end
        expect_eq({"upd_rd_", port}, 32'(exp_rd_q[0]), 32'(rd));
        expect_eq({"upd_data_", port}, exp_data_q[0], data);
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        int idx;
        // Port A holds the older of a pair
        if (upd_en_a) pop_update("a", upd_rd_a, upd_data_a);
        if (upd_en_b) pop_update("b", upd_rd_b, upd_data_b);
        if (mem_store_valid) begin
            idx = find_store(mem_store_addr);
            assert (idx >= 0) else begin
                $display("Store to %h offered at %0t ns but not outstanding",
                         mem_store_addr, $time);
                abort_run();
            end
            expect_eq("mem_store_data", st_data_q[idx], mem_store_data);
        end
    endtask

    // Advance to the next falling edge, check, drop the strobes
    task automatic tick();
        @(negedge clk);
        check_outputs();
        alloc        = 1'b0;
        fin_valid    = 1'b0;
        store_finish = 1'b0;
    endtask

    task automatic alloc_instr(input logic is_store, input logic [RW-1:0] rd,
                               input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        expect_eq("alloc_tag", 32'(exp_tail), 32'(alloc_tag));
        m_store[exp_tail] = is_store;
        m_rd[exp_tail]    = rd;
        m_addr[exp_tail]  = is_store ? {store_seq, addr[15:0]} : addr;
        m_data[exp_tail]  = data;
        if (is_store) begin
            store_seq = store_seq + 16'd1;
        end else begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
        end
        pend_q.push_back(exp_tail);
        exp_tail = exp_tail + core_types_pkg::rob_tag_t'(1);
        alloc    = 1'b1;
    endtask

    task automatic alloc_random(input logic is_store);
        alloc_instr(is_store, RW'(rand_bits(RW)), rand_bits(XLEN), rand_bits(XLEN));
    endtask

    task automatic finish_tag(input core_types_pkg::rob_tag_t tag);
        int pos;
        pos = -1;
        foreach (pend_q[i]) begin
            if (pend_q[i] == tag) pos = i;
        end
        if (pos >= 0) pend_q.delete(pos);
        fin_valid    = 1'b1;
        fin_tag      = tag;
        fin_is_store = m_store[tag];
        fin_rd       = m_rd[tag];
        fin_addr     = m_addr[tag];
        fin_data     = m_data[tag];
        if (m_store[tag]) begin
            st_addr_q.push_back(m_addr[tag]);
            st_data_q.push_back(m_data[tag]);
        end
    endtask

    // Memory completes the store on offer right now
    task automatic release_offered();
        int idx;
        idx            = find_store(mem_store_addr);
        store_finish   = 1'b1;
        store_fin_addr = mem_store_addr;
        if (idx >= 0) begin
            st_addr_q.delete(idx);
            st_data_q.delete(idx);
        end
    endtask

    task automatic wait_updates(input int left, input int max_cyc);
        int cyc;
        cyc = 0;
        while (exp_rd_q.size() > left) begin
            tick();
            cyc++;
            assert (cyc < max_cyc) else begin
                $display("Timed out at %0t ns with %0d register updates still due",
                         $time, exp_rd_q.size());
                abort_run();
            end
        end
    endtask

    task automatic drain_stores(input int max_cyc);
        int cyc;
        cyc = 0;
        while (st_addr_q.size() > 0) begin
            if (mem_store_valid) release_offered();
            tick();
            cyc++;
            assert (cyc < max_cyc) else begin
                $display("Timed out at %0t ns with %0d stores not released",
                         $time, st_addr_q.size());
                abort_run();
            end
        end
        tick();
        expect_eq("mem_store_valid", 32'd0, 32'(mem_store_valid));
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic check_reset_state();
        expect_eq("rob_full", 32'd0, 32'(rob_full));
        expect_eq("upd_en_a", 32'd0, 32'(upd_en_a));
        expect_eq("upd_en_b", 32'd0, 32'(upd_en_b));
        expect_eq("mem_store_valid", 32'd0, 32'(mem_store_valid));
        expect_eq("alloc_tag", 32'd0, 32'(alloc_tag));
    endtask

    // Results arrive out of order, updates leave in tag order
    task automatic run_inorder_retire();
        int                       order [4] = '{3, 1, 0, 2};
        core_types_pkg::rob_tag_t base;
        base = exp_tail;
        for (int i = 0; i < 4; i++) begin
            alloc_random(1'b0);
            tick();
        end
        for (int i = 0; i < 4; i++) begin
            finish_tag(base + core_types_pkg::rob_tag_t'(order[i]));
            tick();
        end
        wait_updates(0, INORDER_CYC);
    endtask

    task automatic fill_rob();
        core_types_pkg::rob_tag_t base;
        base = exp_tail;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            expect_eq("rob_full", 32'd0, 32'(rob_full));
            alloc_random(1'b0);
            tick();
        end
        expect_eq("rob_full", 32'd1, 32'(rob_full));
        // Request while full, must not move the tail
        alloc = 1'b1;
        tick();
        expect_eq("alloc_tag", 32'(base), 32'(alloc_tag));
        expect_eq("rob_full", 32'd1, 32'(rob_full));
        finish_tag(base);
        tick();
        wait_updates(ROB_DEPTH - 1, FULL_CYC);
        expect_eq("rob_full", 32'd0, 32'(rob_full));
        while (pend_q.size() > 0) begin
            finish_tag(pend_q[0]);
            tick();
        end
        wait_updates(0, FULL_CYC);
    endtask

    // Two non-stores among six stores, results youngest first
    task automatic store_path();
        for (int i = 0; i < 8; i++) begin
            alloc_random((i % 3) != 2);
            tick();
        end
        while (pend_q.size() > 0) begin
            finish_tag(pend_q[pend_q.size() - 1]);
            tick();
        end
        drain_stores(STORE_CYC);
        wait_updates(0, STORE_CYC);
        // Stores leave no late register update behind
        repeat (4) tick();
    endtask

    task automatic store_backpressure();
        logic [XLEN-1:0] first_addr;
        logic [XLEN-1:0] held_addr;
        for (int i = 0; i < SB_DEPTH + 2; i++) begin
            alloc_random(i <= SB_DEPTH);
            if (i == 0) first_addr = m_addr[exp_tail - core_types_pkg::rob_tag_t'(1)];
            if (i == SB_DEPTH) held_addr = m_addr[exp_tail - core_types_pkg::rob_tag_t'(1)];
            tick();
        end
        while (pend_q.size() > 0) begin
            finish_tag(pend_q[0]);
            tick();
        end
        // Oldest store took the highest slot and stays on offer
        repeat (12) begin
            tick();
            expect_eq("mem_store_valid", 32'd1, 32'(mem_store_valid));
            expect_eq("mem_store_addr", first_addr, mem_store_addr);
        end
        assert (exp_rd_q.size() == 1) else begin
            $display("Non-store retired past a full store buffer by %0t ns", $time);
            abort_run();
        end
        release_offered();
        tick();
        wait_updates(0, BP_CYC);
        // Held store fills the freed highest slot
        expect_eq("mem_store_addr", held_addr, mem_store_addr);
        drain_stores(BP_CYC);
    endtask

    task automatic random_mix();
        int issued;
        int cyc;
        int pos;
        issued = 0;
        cyc    = 0;
        while (issued < N_RANDOM || pend_q.size() > 0 || exp_rd_q.size() > 0 ||
               st_addr_q.size() > 0) begin
            // Finish before allocating, so a new tag is never finished in its own cycle
            if (pend_q.size() > 0 && rand_bits(1) == 32'd1) begin
                pos = int'(rand_bits(4)) % pend_q.size();
                finish_tag(pend_q[pos]);
            end
            if (issued < N_RANDOM && !rob_full && rand_bits(1) == 32'd1) begin
                alloc_random(rand_bits(1) == 32'd1);
                issued++;
            end
            if (mem_store_valid && rand_bits(1) == 32'd1) release_offered();
            tick();
            cyc++;
            assert (cyc < RANDOM_CYC) else begin
                $display("Random mix stuck at %0t ns after %0d allocations", $time, issued);
                abort_run();
            end
        end
        tick();
        expect_eq("mem_store_valid", 32'd0, 32'(mem_store_valid));
    endtask

    initial begin
        lfsr           = 32'd87684;
        exp_tail       = '0;
        store_seq      = 16'd1;
        rst_n          = 1'b0;
        alloc          = 1'b0;
        fin_valid      = 1'b0;
        fin_tag        = '0;
        fin_is_store   = 1'b0;
        fin_rd         = '0;
        fin_addr       = '0;
        fin_data       = '0;
        store_finish   = 1'b0;
        store_fin_addr = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        run_inorder_retire();
        fill_rob();
        store_path();
        store_backpressure();
        random_mix();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/core_cfg_pkg.sv
verilog/core_types_pkg.sv
verilog/retire_if.sv
verilog/store_write_if.sv
verilog/reorder_buffer.sv
verilog/completion_unit.sv
verilog/store_buffer.sv
verilog/back_end_core.sv
verif/back_end_core_tb.sv

//--- verilog/back_end_core.sv
`timescale 1ns/1ps
`default_nettype none

module back_end_core #(
    parameter int ROB_DEPTH = core_cfg_pkg::ROB_DEPTH_DEF,
    parameter int SB_DEPTH  = core_cfg_pkg::SB_DEPTH_DEF
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    // Allocation
    input  wire logic                               alloc,
    output core_types_pkg::rob_tag_t                alloc_tag,
    output logic                                    rob_full,
    // Execution results
    input  wire logic                               fin_valid,
    input  wire core_types_pkg::rob_tag_t           fin_tag,
    input  wire logic                               fin_is_store,
    input  wire logic [core_cfg_pkg::REG_ADDR_W-1:0] fin_rd,
    input  wire logic [core_cfg_pkg::XLEN-1:0]      fin_addr,
    input  wire logic [core_cfg_pkg::XLEN-1:0]      fin_data,
    // Register updates
    output logic                                    upd_en_a,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]     upd_rd_a,
    output logic [core_cfg_pkg::XLEN-1:0]           upd_data_a,
    output logic                                    upd_en_b,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]     upd_rd_b,
    output logic [core_cfg_pkg::XLEN-1:0]           upd_data_b,
    // Memory side of the store buffer
    output logic                                    mem_store_valid,
    output logic [core_cfg_pkg::XLEN-1:0]           mem_store_addr,
    output logic [core_cfg_pkg::XLEN-1:0]           mem_store_data,
    input  wire logic                               store_finish,
    input  wire logic [core_cfg_pkg::XLEN-1:0]      store_fin_addr
);

    core_types_pkg::rob_entry_t fin_entry;
    logic [1:0]                 sb_free;

    retire_if      u_retire ();
    store_write_if u_sb_wr ();

    // Result fields packed into one entry
    assign fin_entry = '{is_store: fin_is_store, rd: fin_rd, addr: fin_addr, data: fin_data};

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
        .clk, .rst_n, .alloc, .alloc_tag, .rob_full,
        .fin_valid, .fin_tag, .fin_entry, .sb_free,
        .retire (u_retire.source)
    );

    completion_unit i_cmp (
        .clk, .rst_n,
        .retire (u_retire.sink),
        .sb_wr  (u_sb_wr.source),
        .upd_en_a, .upd_en_b, .upd_rd_a, .upd_rd_b, .upd_data_a, .upd_data_b
    );

    store_buffer #(.SB_DEPTH(SB_DEPTH)) i_sb (
        .clk, .rst_n,
        .sb_wr (u_sb_wr.sink),
        .sb_free, .mem_store_valid, .mem_store_addr, .mem_store_data,
        .store_finish, .store_fin_addr
    );

endmodule

`default_nettype wire

//--- verilog/completion_unit.sv
`timescale 1ns/1ps
`default_nettype none

module completion_unit (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    retire_if.sink                                  retire,
    store_write_if.source                           sb_wr,
    output logic                                    upd_en_a,
    output logic                                    upd_en_b,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]     upd_rd_a,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]     upd_rd_b,
    output logic [core_cfg_pkg::XLEN-1:0]           upd_data_a,
    output logic [core_cfg_pkg::XLEN-1:0]           upd_data_b
);

    logic                         st_0;
    logic                         st_1;
    core_types_pkg::store_entry_t se_0;
    core_types_pkg::store_entry_t se_1;

    //////////////////////////////
    // Store path
    //////////////////////////////

    assign st_0 = retire.retire_valid_0 & retire.retire_entry_0.is_store;
    assign st_1 = retire.retire_valid_1 & retire.retire_entry_1.is_store;

    assign se_0 = '{addr: retire.retire_entry_0.addr, data: retire.retire_entry_0.data};
    assign se_1 = '{addr: retire.retire_entry_1.addr, data: retire.retire_entry_1.data};

    // Compact onto write 0 when only the younger slot is a store
    assign sb_wr.wr_en_0    = st_0 | st_1;
    assign sb_wr.wr_entry_0 = st_0 ? se_0 : se_1;
    assign sb_wr.wr_en_1    = st_0 & st_1;
    assign sb_wr.wr_entry_1 = se_1;

    //////////////////////////////
    // Register update path
    //////////////////////////////

    // Port A follows slot 0, port B follows slot 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_en_a   <= 1'b0;
            upd_en_b   <= 1'b0;
            upd_rd_a   <= '0;
            upd_rd_b   <= '0;
            upd_data_a <= '0;
            upd_data_b <= '0;
        end else begin
            upd_en_a   <= retire.retire_valid_0 & ~retire.retire_entry_0.is_store;
            upd_en_b   <= retire.retire_valid_1 & ~retire.retire_entry_1.is_store;
            // Idle ports read as zero
            upd_rd_a   <= (retire.retire_valid_0 & ~st_0) ? retire.retire_entry_0.rd : '0;
            upd_rd_b   <= (retire.retire_valid_1 & ~st_1) ? retire.retire_entry_1.rd : '0;
            upd_data_a <= (retire.retire_valid_0 & ~st_0) ? retire.retire_entry_0.data : '0;
            upd_data_b <= (retire.retire_valid_1 & ~st_1) ? retire.retire_entry_1.data : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // One machine word, used for both store addresses and data
    localparam int XLEN = 32;

    // Architectural destination register index
    localparam int REG_ADDR_W = 5;

    //////////////////////////////
    // Default table depths
    //////////////////////////////

    // Reorder buffer entries, power of two
    localparam int ROB_DEPTH_DEF = 16;

    // Store buffer entries, power of two
    localparam int SB_DEPTH_DEF = 8;

    // The back end retires at most two entries per cycle,
    // so the store buffer must hold at least two stores
    // for both retire slots to be usable with stores

endpackage

`default_nettype wire

//--- verilog/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    //////////////////////////////
    // Tags
    //////////////////////////////

    // Width of a reorder buffer index at the default depth
    localparam int TAG_W = $clog2(core_cfg_pkg::ROB_DEPTH_DEF);

    // Reorder buffer index, handed out at allocation
    typedef logic [TAG_W-1:0] rob_tag_t;

    //////////////////////////////
    // Entry payloads
    //////////////////////////////

    // Finished instruction as held in the reorder buffer
    // Store flag on top, then rd, then address and data (70 bits)
    typedef struct packed {
        logic                                is_store;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
        logic [core_cfg_pkg::XLEN-1:0]       addr;
        logic [core_cfg_pkg::XLEN-1:0]       data;
    } rob_entry_t;

    // Buffered store waiting for memory
    // Address in the upper word, data in the lower word
    typedef struct packed {
        logic [core_cfg_pkg::XLEN-1:0] addr;
        logic [core_cfg_pkg::XLEN-1:0] data;
    } store_entry_t;

endpackage

`default_nettype wire

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       alloc,
    output core_types_pkg::rob_tag_t        alloc_tag,
    output logic                            rob_full,
    input  wire logic                       fin_valid,
    input  wire core_types_pkg::rob_tag_t   fin_tag,
    input  wire core_types_pkg::rob_entry_t fin_entry,
    input  wire logic [1:0]                 sb_free,
    retire_if.source                        retire
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = TAG_W + 1;

    // Entry table, written only when an instruction finishes
    core_types_pkg::rob_entry_t entries [ROB_DEPTH];

    // Per-entry state
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] finished;

    // Circular pointers and occupancy
    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [TAG_W-1:0] head_p1;
    logic [TAG_W-1:0] fin_idx;
    logic             alloc_fire;
    logic             fin_fire;
    logic             fin_0;
    logic             fin_1;
    logic             st_0;
    logic             st_1;
    logic             ret_0;
    logic             ret_1;

    //////////////////////////////
    // Allocation and finish
    //////////////////////////////

    assign rob_full   = (count == CNT_W'(ROB_DEPTH));
    assign alloc_tag  = core_types_pkg::rob_tag_t'(tail);
    // Requests while full are dropped
    assign alloc_fire = alloc & ~rob_full;

    assign fin_idx  = fin_tag[TAG_W-1:0];
    // Only a busy entry that has not finished yet accepts a result
    assign fin_fire = fin_valid & busy[fin_idx] & ~finished[fin_idx];

    //////////////////////////////
    // Retire decision
    //////////////////////////////

    assign head_p1 = head + TAG_W'(1);

    // Finished implies busy
    assign fin_0 = finished[head];
    assign fin_1 = finished[head_p1];
    assign st_0  = entries[head].is_store;
    assign st_1  = entries[head_p1].is_store;

    // Older slot needs one free store slot if it is a store
    assign ret_0 = fin_0 & (~st_0 | sb_free[0]);

    // Younger slot needs two free slots when both are stores
    assign ret_1 = ret_0 & fin_1 & (~st_1 | (st_0 ? sb_free[1] : sb_free[0]));

    assign retire.retire_valid_0 = ret_0;
    assign retire.retire_valid_1 = ret_1;
    assign retire.retire_entry_0 = entries[head];
    assign retire.retire_entry_1 = entries[head_p1];

    //////////////////////////////
    // State update
    //////////////////////////////

    // Payload written at finish
    always_ff @(posedge clk) begin
        if (fin_fire) begin
            entries[fin_idx] <= fin_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= '0;
            finished <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            // Claim the tail entry
            if (alloc_fire) begin
                busy[tail]     <= 1'b1;
                finished[tail] <= 1'b0;
                tail           <= tail + TAG_W'(1);
            end

            if (fin_fire) begin
                finished[fin_idx] <= 1'b1;
            end

            // Retired entries never overlap the tail or the finish index
            if (ret_0) begin
                busy[head]     <= 1'b0;
                finished[head] <= 1'b0;
            end
            if (ret_1) begin
                busy[head_p1]     <= 1'b0;
                finished[head_p1] <= 1'b0;
            end

            head  <= head + TAG_W'(ret_0) + TAG_W'(ret_1);
            count <= count + CNT_W'(alloc_fire) - CNT_W'(ret_0) - CNT_W'(ret_1);
        end
    end

endmodule

`default_nettype wire

//--- verilog/retire_if.sv
`timescale 1ns/1ps
`default_nettype none

// Two retire slots from the reorder buffer to the completion stage
// Slot 0 is the older entry; slot 1 only valid together with slot 0
// A valid slot means the entry leaves the ROB at this edge
interface retire_if;

    logic                     retire_valid_0;
    logic                     retire_valid_1;
    core_types_pkg::rob_entry_t retire_entry_0;
    core_types_pkg::rob_entry_t retire_entry_1;

    // Reorder buffer side
    modport source (
        output retire_valid_0, retire_valid_1,
        output retire_entry_0, retire_entry_1
    );

    // Completion stage side
    modport sink (
        input retire_valid_0, retire_valid_1,
        input retire_entry_0, retire_entry_1
    );

endinterface

`default_nettype wire

//--- verilog/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer #(
    parameter int SB_DEPTH = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    store_write_if.sink                     sb_wr,
    output logic [1:0]                      sb_free,
    output logic                            mem_store_valid,
    output logic [core_cfg_pkg::XLEN-1:0]   mem_store_addr,
    output logic [core_cfg_pkg::XLEN-1:0]   mem_store_data,
    input  wire logic                       store_finish,
    input  wire logic [core_cfg_pkg::XLEN-1:0] store_fin_addr
);

    localparam int IDX_W = $clog2(SB_DEPTH);

    core_types_pkg::store_entry_t stores [SB_DEPTH];
    logic [SB_DEPTH-1:0]          busy;

    logic [IDX_W-1:0] free_idx_0;
    logic [IDX_W-1:0] free_idx_1;
    logic             free_ok_0;
    logic             free_ok_1;
    logic [IDX_W-1:0] rel_idx;
    logic             rel_hit;
    logic [IDX_W-1:0] off_idx;
    logic             off_ok;

    //////////////////////////////
    // Searches
    //////////////////////////////

    // Free slots; ascending scan leaves the highest in slot 0
    // and the one below it in slot 1
    always_comb begin
        free_idx_0 = '0;
        free_idx_1 = '0;
        free_ok_0  = 1'b0;
        free_ok_1  = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (!busy[i]) begin
                free_idx_1 = free_idx_0;
                free_ok_1  = free_ok_0;
                free_idx_0 = IDX_W'(i);
                free_ok_0  = 1'b1;
            end
        end
    end

    // Release match by address, highest busy index wins
    always_comb begin
        rel_idx = '0;
        rel_hit = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (busy[i] && (stores[i].addr == store_fin_addr)) begin
                rel_idx = IDX_W'(i);
                rel_hit = 1'b1;
            end
        end
    end

    // Store offered to memory, highest busy index
    always_comb begin
        off_idx = '0;
        off_ok  = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (busy[i]) begin
                off_idx = IDX_W'(i);
                off_ok  = 1'b1;
            end
        end
    end

    // Occupancy as seen before this edge
    assign sb_free         = {free_ok_1, free_ok_0};
    assign mem_store_valid = off_ok;
    assign mem_store_addr  = stores[off_idx].addr;
    assign mem_store_data  = stores[off_idx].data;

    //////////////////////////////
    // Table update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (sb_wr.wr_en_0 && free_ok_0) begin
            stores[free_idx_0] <= sb_wr.wr_entry_0;
        end
        if (sb_wr.wr_en_1 && free_ok_1) begin
            stores[free_idx_1] <= sb_wr.wr_entry_1;
        end
    end

    // Written slots are free and the released slot is busy, never the same
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (sb_wr.wr_en_0 && free_ok_0) begin
                busy[free_idx_0] <= 1'b1;
            end
            if (sb_wr.wr_en_1 && free_ok_1) begin
                busy[free_idx_1] <= 1'b1;
            end
            if (store_finish && rel_hit) begin
                busy[rel_idx] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/store_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// Two store buffer write ports, driven by the completion stage
// Write 0 always carries the older store
interface store_write_if;

    logic                         wr_en_0;
    logic                         wr_en_1;
    core_types_pkg::store_entry_t wr_entry_0;
    core_types_pkg::store_entry_t wr_entry_1;

    // Completion stage side
    modport source (
        output wr_en_0, wr_en_1, wr_entry_0, wr_entry_1
    );

    // Store buffer side
    modport sink (
        input wr_en_0, wr_en_1, wr_entry_0, wr_entry_1
    );

endinterface

`default_nettype wire
